// ==== list.f ====
verilog/roce_tx_pkg.sv
verilog/beat_stream_if.sv
verilog/sync_fifo.sv
verilog/pattern_source.sv
verilog/rdma_write_segmenter.sv
verilog/packet_emitter.sv
verilog/roce_write_sender.sv
sim/roce_tx_properties.sv
sim/tb_roce_write_sender.sv

// ==== sim/roce_tx_properties.sv ====
`timescale 1ns/1ps

module roce_tx_properties
  import roce_tx_pkg::*;
(
  input logic                        clk,
  input logic                        rst,
  input logic                        hdr_valid,
  input logic                        hdr_ready,
  input logic [$bits(tx_desc_t)-1:0] hdr,
  input logic                        tvalid,
  input logic                        tready,
  input logic                        tlast,
  input logic [KEEP_W-1:0]           tkeep,
  input logic [$bits(beat_t)-1:0]    beat,
  input logic                        busy
);

  logic        in_pkt;
  int unsigned fail_count = 0;

  // header accepted, payload of that packet not finished yet
  always_ff @(posedge clk) begin
    if (rst) begin
      in_pkt <= 1'b0;
    end else if (hdr_valid && hdr_ready) begin
      in_pkt <= 1'b1;
    end else if (tvalid && tready && tlast) begin
      in_pkt <= 1'b0;
    end
  end

  a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
    hdr_valid && !hdr_ready |=> hdr_valid && $stable(hdr))
    else begin
      $error("header dropped or changed while hdr_ready was low");
      fail_count++;
    end

  a_beat_hold: assert property (@(posedge clk) disable iff (rst)
    tvalid && !tready |=> tvalid && $stable(beat))
    else begin
      $error("beat dropped or changed while tready was low");
      fail_count++;
    end

  a_no_early_beat: assert property (@(posedge clk) disable iff (rst)
    !in_pkt |-> !tvalid)
    else begin
      $error("tvalid raised before the packet header was taken");
      fail_count++;
    end

  a_busy_reset: assert property (@(posedge clk) rst |=> !busy)
    else begin
      $error("busy high right after reset");
      fail_count++;
    end

  a_keep_nonzero: assert property (@(posedge clk) disable iff (rst)
    tvalid && tlast |-> tkeep != '0)
    else begin
      $error("tlast beat with no byte enabled");
      fail_count++;
    end

endmodule

bind roce_write_sender roce_tx_properties u_props (
  .clk       (clk),
  .rst       (rst),
  .hdr_valid (hdr_valid),
  .hdr_ready (hdr_ready),
  .hdr       ({bth_op_code, bth_psn, bth_dest_qp, bth_ack_req,
               reth_valid, reth_v_addr, reth_r_key, reth_length}),
  .tvalid    (tvalid),
  .tready    (tready),
  .tlast     (tlast),
  .tkeep     (tkeep),
  .beat      ({tdata, tkeep, tlast}),
  .busy      (busy)
);

// ==== sim/tb_roce_write_sender.sv ====
`timescale 1ns/1ps

module tb_roce_write_sender
  import roce_tx_pkg::*;
();

  typedef struct packed {
    logic [31:0] len;
    logic [15:0] msgs;
    logic [12:0] pmtu;
    qpn_t        qpn;
    psn_t        psn;
    logic [31:0] rkey;
    logic [63:0] addr;
    logic        bp;
  } row_t;

  localparam int N_ROWS = 6;
  localparam row_t ROWS [N_ROWS] = '{
    '{32'd8,    16'd3, 13'd256,  24'h000011, 24'h000100, 32'h1234_0001, 64'h0000_1000, 1'b0},
    '{32'd256,  16'd2, 13'd256,  24'h000022, 24'h000200, 32'h1234_0002, 64'h1_0000_0000, 1'b1},
    '{32'd1000, 16'd2, 13'd1024, 24'h000033, 24'h000300, 32'h5A5A_0003, 64'h0004_0008, 1'b0},
    '{32'd700,  16'd3, 13'd256,  24'h000044, 24'h000400, 32'h0000_0004, 64'h0020_0000, 1'b1},
    '{32'd4096, 16'd1, 13'd4096, 24'h000055, 24'h7FFFF0, 32'h0000_0005, 64'h7F00_0000, 1'b0},
    '{32'd1000, 16'd3, 13'd256,  24'hABCDEF, 24'hFFFFFE, 32'h0000_0006, 64'hFFFF_FE00, 1'b1}
  };

  logic              clk;
  logic              rst;
  logic              start;
  logic [31:0]       dma_length;
  logic [15:0]       n_messages;
  logic [12:0]       pmtu;
  qpn_t              rem_qpn;
  psn_t              rem_psn;
  logic [31:0]       r_key;
  logic [63:0]       rem_addr;
  logic              hdr_valid;
  logic              hdr_ready;
  logic [7:0]        bth_op_code;
  psn_t              bth_psn;
  qpn_t              bth_dest_qp;
  logic              bth_ack_req;
  logic              reth_valid;
  logic [63:0]       reth_v_addr;
  logic [31:0]       reth_r_key;
  logic [31:0]       reth_length;
  logic [DATA_W-1:0] tdata;
  logic [KEEP_W-1:0] tkeep;
  logic              tvalid;
  logic              tlast;
  logic              tready;
  logic              busy;

  tx_desc_t    exp_desc [$];
  beat_t       exp_beat [$];
  logic [15:0] lfsr;
  logic        bp_on;
  int unsigned cycles = 0;
  int unsigned limit;
  int unsigned n_desc = 0;
  int unsigned n_beat = 0;

  roce_write_sender u_roce_write_sender (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bit(output logic b);
    b = lfsr[0];
    lfsr = lfsr_step(lfsr);
  endtask

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  function automatic int unsigned count_beats(input row_t r);
    return ((r.len + 32'd7) / 32'd8) * r.msgs;
  endfunction

  // one enable bit per byte still left in the message
  function automatic logic [KEEP_W-1:0] keep_for(input logic [31:0] rem);
    logic [KEEP_W-1:0] k;
    for (int i = 0; i < KEEP_W; i++) begin
      k[i] = (i < rem);
    end
    return k;
  endfunction

  task automatic build_expected(input row_t r);
    tx_desc_t    d;
    beat_t       b;
    psn_t        psn;
    logic [63:0] addr;
    logic [31:0] done;
    logic [31:0] plen;
    logic [31:0] off;
    logic        is_first;
    logic        is_last;
    psn = r.psn;
    addr = r.addr;
    for (int m = 0; m < r.msgs; m++) begin
      done = '0;
      while (done < r.len) begin
        plen = (r.len - done > 32'(r.pmtu)) ? 32'(r.pmtu) : r.len - done;
        is_first = (done == '0);
        is_last = (done + plen == r.len);
        d = '0;
        d.bth.op_code = is_first ? (is_last ? OP_WRITE_ONLY : OP_WRITE_FIRST)
                                 : (is_last ? OP_WRITE_LAST : OP_WRITE_MIDDLE);
        d.bth.psn = psn;
        d.bth.dest_qp = r.qpn;
        d.bth.ack_req = is_last;
        d.reth_valid = is_first;
        d.reth = '{addr, r.rkey, r.len};
        exp_desc.push_back(d);
        psn = psn + 24'd1;
        for (off = done; off < done + plen; off = off + BYTES_PER_BEAT) begin
          b.data = {~off, off};
          b.keep = keep_for(r.len - off);
          b.last = (off + BYTES_PER_BEAT >= done + plen);
          exp_beat.push_back(b);
        end
        done = done + plen;
      end
      addr = addr + 64'(r.len);
    end
  endtask

  task automatic check_desc(input bth_t got_bth, input logic got_rv, input reth_t got_reth,
                            input tx_desc_t exp);
    if (got_bth !== exp.bth || got_rv !== exp.reth_valid) begin
      $display("ERR %0t: header %0d op %02h psn %06h qp %06h ack %0b reth %0b", $time, n_desc,
               got_bth.op_code, got_bth.psn, got_bth.dest_qp, got_bth.ack_req, got_rv);
      $display("ERR %0t: expected op %02h psn %06h qp %06h ack %0b reth %0b", $time,
               exp.bth.op_code, exp.bth.psn, exp.bth.dest_qp, exp.bth.ack_req,
               exp.reth_valid);
      abort_run();
    end else if (exp.reth_valid && got_reth !== exp.reth) begin
      $display("ERR %0t: header %0d reth %h %h %0d, expected %h %h %0d", $time, n_desc,
               got_reth.v_addr, got_reth.r_key, got_reth.length,
               exp.reth.v_addr, exp.reth.r_key, exp.reth.length);
      abort_run();
    end else begin
      n_desc++;
    end
  endtask

  task automatic check_beat(input beat_t got, input beat_t exp);
    if (got !== exp) begin
      $display("ERR %0t: beat %0d data %h keep %02h last %0b, expected %h %02h %0b",
               $time, n_beat, got.data, got.keep, got.last, exp.data, exp.keep, exp.last);
      abort_run();
    end else begin
      n_beat++;
    end
  endtask

  // readies move only on the falling edge
  task automatic tick();
    logic b;
    @(negedge clk);
    if (bp_on) begin
      draw_bit(b);
      hdr_ready = b;
      draw_bit(b);
      tready = b;
    end else begin
      hdr_ready = 1'b1;
      tready = 1'b1;
    end
  endtask

  task automatic drive_settings(input row_t r);
    dma_length = r.len;
    n_messages = r.msgs;
    pmtu = r.pmtu;
    rem_qpn = r.qpn;
    rem_psn = r.psn;
    r_key = r.rkey;
    rem_addr = r.addr;
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout, the run did not finish within %0d cycles", limit);
      abort_run();
    end else if (u_roce_write_sender.u_props.fail_count != 0) begin
      $display("a bound assertion on the DUT outputs failed");
      abort_run();
    end else if (!rst) begin
      if (hdr_valid && hdr_ready) begin
        if (exp_desc.size() == 0) begin
          $display("header with psn %06h arrived when none was expected", bth_psn);
          abort_run();
        end else begin
          check_desc(bth_t'({bth_op_code, bth_psn, bth_dest_qp, bth_ack_req}), reth_valid,
                     reth_t'({reth_v_addr, reth_r_key, reth_length}), exp_desc.pop_front());
        end
      end
      if (tvalid && tready) begin
        if (exp_beat.size() == 0) begin
          $display("payload beat arrived when none was expected");
          abort_run();
        end else begin
          check_beat(beat_t'({tdata, tkeep, tlast}), exp_beat.pop_front());
        end
      end
    end
  end

  initial begin
    rst = 1'b1;
    start = 1'b0;
    dma_length = '0;
    n_messages = '0;
    pmtu = '0;
    rem_qpn = '0;
    rem_psn = '0;
    r_key = '0;
    rem_addr = '0;
    hdr_ready = 1'b0;
    tready = 1'b0;
    bp_on = 1'b0;
    lfsr = 16'd10;
    limit = 0;
    foreach (ROWS[i]) begin
      limit += 8 * count_beats(ROWS[i]) + 50;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (ROWS[i]) begin
      build_expected(ROWS[i]);
      bp_on = ROWS[i].bp;
      tick();
      drive_settings(ROWS[i]);
      start = 1'b1;
      tick();
      if (!busy) begin
        $display("start for row %0d was not taken", i);
        abort_run();
      end
      // start held with other settings while busy must change nothing
      rem_psn = ~ROWS[i].psn;
      dma_length = ROWS[i].len + 32'd8;
      tick();
      start = 1'b0;
      drive_settings(ROWS[i]);
      while (busy) begin
        // busy must drop in the cycle after the final beat
        if (exp_beat.size() == 0) begin
          $display("busy still high after the last beat of row %0d", i);
          abort_run();
        end
        tick();
      end
      if (exp_desc.size() != 0 || exp_beat.size() != 0) begin
        $display("busy fell in row %0d with %0d headers and %0d beats still missing",
                 i, exp_desc.size(), exp_beat.size());
        abort_run();
      end
    end
    tick();
    if (u_roce_write_sender.u_props.fail_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("a bound assertion on the DUT outputs failed");
      abort_run();
    end
  end

endmodule

// ==== verilog/beat_stream_if.sv ====
`timescale 1ns/1ps

interface beat_stream_if
  import roce_tx_pkg::*;
();

  logic [DATA_W-1:0] data;
  logic [KEEP_W-1:0] keep;
  // end of message here, not end of packet
  logic              last;
  logic              valid;
  logic              ready;

  modport src (
    output data, keep, last, valid,
    input  ready
  );

  modport snk (
    input  data, keep, last, valid,
    output ready
  );

endinterface

// ==== verilog/packet_emitter.sv ====
`timescale 1ns/1ps

module packet_emitter
  import roce_tx_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic [31:0]       dma_length,
  input  logic [15:0]       n_messages,
  output logic              accept,
  input  tx_desc_t          desc_data,
  input  logic              desc_valid,
  output logic              desc_ready,
  input  beat_t             beat_data,
  input  logic              beat_valid,
  output logic              beat_ready,
  output logic              hdr_valid,
  input  logic              hdr_ready,
  output logic [7:0]        bth_op_code,
  output psn_t              bth_psn,
  output qpn_t              bth_dest_qp,
  output logic              bth_ack_req,
  output logic              reth_valid,
  output logic [63:0]       reth_v_addr,
  output logic [31:0]       reth_r_key,
  output logic [31:0]       reth_length,
  output logic [DATA_W-1:0] tdata,
  output logic [KEEP_W-1:0] tkeep,
  output logic              tvalid,
  output logic              tlast,
  input  logic              tready,
  output logic              busy
);

  typedef enum logic {
    PH_HDR,
    PH_PAY
  } phase_t;

  phase_t      phase;
  logic [15:0] msgs_left;
  logic        hdr_fire;
  logic        pkt_done;
  logic        msg_done;

  assign accept = start && !busy && (dma_length != '0);

  assign hdr_valid   = (phase == PH_HDR) && desc_valid;
  assign hdr_fire    = hdr_valid && hdr_ready;
  assign bth_op_code = desc_data.bth.op_code;
  assign bth_psn     = desc_data.bth.psn;
  assign bth_dest_qp = desc_data.bth.dest_qp;
  assign bth_ack_req = desc_data.bth.ack_req;
  assign reth_valid  = desc_data.reth_valid;
  assign reth_v_addr = desc_data.reth.v_addr;
  assign reth_r_key  = desc_data.reth.r_key;
  assign reth_length = desc_data.reth.length;

  assign tvalid     = (phase == PH_PAY) && beat_valid;
  assign beat_ready = (phase == PH_PAY) && tready;
  assign tdata      = beat_data.data;
  assign tkeep      = beat_data.keep;
  assign tlast      = beat_data.last;

  // descriptor stays at the FIFO head until its packet is out
  assign pkt_done   = tvalid && tready && tlast;
  assign desc_ready = pkt_done;
  assign msg_done   = pkt_done && ((bth_op_code == OP_WRITE_LAST) ||
                                   (bth_op_code == OP_WRITE_ONLY));

  always_ff @(posedge clk) begin
    if (rst) begin
      phase     <= PH_HDR;
      busy      <= 1'b0;
      msgs_left <= '0;
    end else begin
      if (hdr_fire) begin
        phase <= PH_PAY;
      end else if (pkt_done) begin
        phase <= PH_HDR;
      end
      if (accept) begin
        busy      <= 1'b1;
        msgs_left <= n_messages;
      end else if (busy) begin
        if (msg_done) begin
          msgs_left <= msgs_left - 16'd1;
          if (msgs_left == 16'd1) begin
            busy <= 1'b0;
          end
        end else if (msgs_left == '0) begin
          // zero messages requested
          busy <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== verilog/pattern_source.sv ====
`timescale 1ns/1ps

module pattern_source
  import roce_tx_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  input  logic [31:0] dma_length,
  input  logic [15:0] n_messages,
  input  logic        accept,
  beat_stream_if.src  beats
);

  localparam int REM_W = $clog2(KEEP_W) + 1;

  logic [31:0] len_q;
  logic [15:0] msgs_left;
  logic [31:0] offset;
  logic        arm;
  logic        active;
  logic        go;
  logic        fire;
  logic [31:0] rem_bytes;

  assign go        = start && accept;
  assign fire      = beats.valid && beats.ready;
  assign rem_bytes = len_q - offset;

  // low word is the byte offset, high word its inverse
  assign beats.valid = active;
  assign beats.data  = {~offset, offset};
  assign beats.last  = (rem_bytes <= 32'(BYTES_PER_BEAT));

  // short final beat keeps the low bytes only
  always_comb begin
    if (beats.last) begin
      beats.keep = ~({KEEP_W{1'b1}} << rem_bytes[REM_W-1:0]);
    end else begin
      beats.keep = '1;
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      len_q <= dma_length;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      arm       <= 1'b0;
      active    <= 1'b0;
      msgs_left <= '0;
      offset    <= '0;
    end else begin
      arm <= go;
      if (go) begin
        msgs_left <= n_messages;
      end
      if (arm) begin
        active <= (msgs_left != '0);
        offset <= '0;
      end else if (fire) begin
        if (beats.last) begin
          // next message restarts at offset zero
          offset    <= '0;
          msgs_left <= msgs_left - 16'd1;
          if (msgs_left == 16'd1) begin
            active <= 1'b0;
          end
        end else begin
          offset <= offset + 32'(BYTES_PER_BEAT);
        end
      end
    end
  end

endmodule

// ==== verilog/rdma_write_segmenter.sv ====
`timescale 1ns/1ps

module rdma_write_segmenter
  import roce_tx_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        accept,
  input  logic [31:0] dma_length,
  input  logic [12:0] pmtu,
  input  qpn_t        rem_qpn,
  input  psn_t        rem_psn,
  input  logic [31:0] r_key,
  input  logic [63:0] rem_addr,
  beat_stream_if.snk  beats,
  output tx_desc_t    desc_data,
  output logic        desc_valid,
  input  logic        desc_ready,
  output beat_t       beat_data,
  output logic        beat_valid,
  input  logic        beat_ready
);

  typedef enum logic {
    ST_HDR,
    ST_DATA
  } state_t;

  state_t      state;
  logic [31:0] len_q;
  logic [12:0] pmtu_q;
  qpn_t        qpn_q;
  logic [31:0] rkey_q;
  psn_t        psn;
  logic [63:0] addr;
  logic [31:0] msg_left;
  logic [12:0] pkt_left;

  logic        first;
  logic        fits;
  logic [12:0] pkt_len;
  logic [7:0]  op;
  logic        pkt_end;
  logic        desc_fire;
  logic        beat_fire;

  assign first   = (msg_left == len_q);
  assign fits    = (msg_left <= {19'd0, pmtu_q});
  assign pkt_len = fits ? msg_left[12:0] : pmtu_q;

  always_comb begin
    if (first && fits) begin
      op = OP_WRITE_ONLY;
    end else if (first) begin
      op = OP_WRITE_FIRST;
    end else if (fits) begin
      op = OP_WRITE_LAST;
    end else begin
      op = OP_WRITE_MIDDLE;
    end
  end

  // header waits for the packet's first beat to be present
  assign desc_valid = (state == ST_HDR) && beats.valid;
  assign desc_fire  = desc_valid && desc_ready;

  always_comb begin
    desc_data              = '0;
    desc_data.bth.op_code  = op;
    desc_data.bth.psn      = psn;
    desc_data.bth.dest_qp  = qpn_q;
    desc_data.bth.ack_req  = fits;
    desc_data.reth_valid   = first;
    desc_data.reth.v_addr  = addr;
    desc_data.reth.r_key   = rkey_q;
    desc_data.reth.length  = len_q;
  end

  assign pkt_end = (pkt_left <= 13'(BYTES_PER_BEAT)) || beats.last;

  assign beat_valid     = (state == ST_DATA) && beats.valid;
  assign beats.ready    = (state == ST_DATA) && beat_ready;
  assign beat_fire      = beat_valid && beat_ready;
  assign beat_data.data = beats.data;
  assign beat_data.keep = beats.keep;
  assign beat_data.last = pkt_end;

  always_ff @(posedge clk) begin
    if (accept) begin
      len_q  <= dma_length;
      pmtu_q <= pmtu;
      qpn_q  <= rem_qpn;
      rkey_q <= r_key;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_HDR;
      psn      <= '0;
      addr     <= '0;
      msg_left <= '0;
      pkt_left <= '0;
    end else if (accept) begin
      state    <= ST_HDR;
      psn      <= rem_psn;
      addr     <= rem_addr;
      msg_left <= dma_length;
    end else if (desc_fire) begin
      state    <= ST_DATA;
      psn      <= psn + 24'd1;
      pkt_left <= pkt_len;
      msg_left <= msg_left - {19'd0, pkt_len};
    end else if (beat_fire) begin
      pkt_left <= pkt_left - 13'(BYTES_PER_BEAT);
      if (pkt_end) begin
        state <= ST_HDR;
      end
      // message boundary, next one lands right after this one
      if (beats.last) begin
        msg_left <= len_q;
        addr     <= addr + {32'd0, len_q};
      end
    end
  end

endmodule

// ==== verilog/roce_tx_pkg.sv ====
package roce_tx_pkg;

  // payload stream geometry
  localparam int DATA_W         = 64;
  localparam int KEEP_W         = 8;
  localparam int BYTES_PER_BEAT = 8;

  // RC RDMA WRITE opcodes
  localparam logic [7:0] OP_WRITE_FIRST  = 8'h06;
  localparam logic [7:0] OP_WRITE_MIDDLE = 8'h07;
  localparam logic [7:0] OP_WRITE_LAST   = 8'h08;
  localparam logic [7:0] OP_WRITE_ONLY   = 8'h0A;

  // buffering between segmenter and emitter
  localparam int DESC_FIFO_DEPTH = 8;
  localparam int BEAT_FIFO_DEPTH = 64;

  typedef logic [23:0] psn_t;
  typedef logic [23:0] qpn_t;

  // base transport header, only the fields this sender fills in
  typedef struct packed {
    logic [7:0] op_code;
    psn_t       psn;
    qpn_t       dest_qp;
    logic       ack_req;
  } bth_t;

  // RDMA extended transport header
  typedef struct packed {
    logic [63:0] v_addr;
    logic [31:0] r_key;
    logic [31:0] length;
  } reth_t;

  // one entry per packet
  typedef struct packed {
    bth_t  bth;
    logic  reth_valid;
    reth_t reth;
  } tx_desc_t;

  // last marks the final beat of a packet
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [KEEP_W-1:0] keep;
    logic              last;
  } beat_t;

endpackage

// ==== verilog/roce_write_sender.sv ====
`timescale 1ns/1ps

module roce_write_sender
  import roce_tx_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic [31:0]       dma_length,
  input  logic [15:0]       n_messages,
  input  logic [12:0]       pmtu,
  input  qpn_t              rem_qpn,
  input  psn_t              rem_psn,
  input  logic [31:0]       r_key,
  input  logic [63:0]       rem_addr,
  output logic              hdr_valid,
  input  logic              hdr_ready,
  output logic [7:0]        bth_op_code,
  output psn_t              bth_psn,
  output qpn_t              bth_dest_qp,
  output logic              bth_ack_req,
  output logic              reth_valid,
  output logic [63:0]       reth_v_addr,
  output logic [31:0]       reth_r_key,
  output logic [31:0]       reth_length,
  output logic [DATA_W-1:0] tdata,
  output logic [KEEP_W-1:0] tkeep,
  output logic              tvalid,
  output logic              tlast,
  input  logic              tready,
  output logic              busy
);

  logic     accept;
  tx_desc_t seg_desc;
  logic     seg_desc_valid;
  logic     seg_desc_ready;
  tx_desc_t fifo_desc;
  logic     fifo_desc_valid;
  logic     fifo_desc_ready;
  beat_t    seg_beat;
  logic     seg_beat_valid;
  logic     seg_beat_ready;
  beat_t    fifo_beat;
  logic     fifo_beat_valid;
  logic     fifo_beat_ready;

  beat_stream_if u_beats ();

  pattern_source u_pattern_source (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .dma_length (dma_length),
    .n_messages (n_messages),
    .accept     (accept),
    .beats      (u_beats.src)
  );

  rdma_write_segmenter u_segmenter (
    .clk        (clk),
    .rst        (rst),
    .accept     (accept),
    .dma_length (dma_length),
    .pmtu       (pmtu),
    .rem_qpn    (rem_qpn),
    .rem_psn    (rem_psn),
    .r_key      (r_key),
    .rem_addr   (rem_addr),
    .beats      (u_beats.snk),
    .desc_data  (seg_desc),
    .desc_valid (seg_desc_valid),
    .desc_ready (seg_desc_ready),
    .beat_data  (seg_beat),
    .beat_valid (seg_beat_valid),
    .beat_ready (seg_beat_ready)
  );

  sync_fifo #(
    .item_t (tx_desc_t),
    .DEPTH  (DESC_FIFO_DEPTH)
  ) u_desc_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (seg_desc),
    .in_valid  (seg_desc_valid),
    .in_ready  (seg_desc_ready),
    .out_data  (fifo_desc),
    .out_valid (fifo_desc_valid),
    .out_ready (fifo_desc_ready)
  );

  sync_fifo #(
    .item_t (beat_t),
    .DEPTH  (BEAT_FIFO_DEPTH)
  ) u_beat_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (seg_beat),
    .in_valid  (seg_beat_valid),
    .in_ready  (seg_beat_ready),
    .out_data  (fifo_beat),
    .out_valid (fifo_beat_valid),
    .out_ready (fifo_beat_ready)
  );

  packet_emitter u_emitter (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .dma_length  (dma_length),
    .n_messages  (n_messages),
    .accept      (accept),
    .desc_data   (fifo_desc),
    .desc_valid  (fifo_desc_valid),
    .desc_ready  (fifo_desc_ready),
    .beat_data   (fifo_beat),
    .beat_valid  (fifo_beat_valid),
    .beat_ready  (fifo_beat_ready),
    .hdr_valid   (hdr_valid),
    .hdr_ready   (hdr_ready),
    .bth_op_code (bth_op_code),
    .bth_psn     (bth_psn),
    .bth_dest_qp (bth_dest_qp),
    .bth_ack_req (bth_ack_req),
    .reth_valid  (reth_valid),
    .reth_v_addr (reth_v_addr),
    .reth_r_key  (reth_r_key),
    .reth_length (reth_length),
    .tdata       (tdata),
    .tkeep       (tkeep),
    .tvalid      (tvalid),
    .tlast       (tlast),
    .tready      (tready),
    .busy        (busy)
  );

endmodule

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter type item_t = logic,
  parameter int  DEPTH  = 8
) (
  input  logic  clk,
  input  logic  rst,
  input  item_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  output item_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != (PTR_W + 1)'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule
